// ==== src/formatBa_defines.svh ====
// Block Ack frame field constants
`ifndef FORMATBA_DEFINES_SVH
`define FORMATBA_DEFINES_SVH

//////////////////////////////////////////////////////////////////////////////
// field lengths in bytes
//////////////////////////////////////////////////////////////////////////////

// duration/ID field
`define BA_DURATION_BYTES 2
// receiver and transmitter address fields, each
`define BA_ADDR_BYTES 6
// BA control field
`define BA_CONTROL_BYTES 2
// BA information field, the bitmap from the BA controller
`define BA_INFO_BYTES 10

//////////////////////////////////////////////////////////////////////////////
// fixed code points
//////////////////////////////////////////////////////////////////////////////

// subtype 1001, type 01 (control), protocol version 00
`define BA_FRMCTRL_BYTE1 8'h94
// first BA control byte, compressed bitmap
`define BA_CONTROL_BYTE0 8'h04

`endif

// ==== src/formatBaPkg.sv ====
// Block Ack formatter types
package formatBaPkg;

  // 48-bit MAC address, sent least significant byte first
  typedef logic [47:0] macAddrT;

  // duration/ID field of the MAC header
  typedef logic [15:0] durationT;

  // one byte on the FCS engine data path
  typedef logic [7:0] fcsByteT;

  // traffic identifier of the received frame
  typedef logic [3:0] tidT;

  // index of a byte inside the current field
  typedef logic [3:0] byteIdxT;

  // frame sequencer states
  typedef enum logic [3:0] {
    baIdle       = 4'd0,
    baWait       = 4'd1,
    baStartTx    = 4'd2,
    baFrmCtrl1   = 4'd3,
    baFrmCtrl2   = 4'd4,
    baDurationId = 4'd5,
    baRa         = 4'd6,
    baTa         = 4'd7,
    baControl    = 4'd8,
    baInfo       = 4'd9,
    baFcs        = 4'd10
  } baStateT;

endpackage

// ==== src/baFrameSequencer.sv ====
// Block Ack frame sequencer
`timescale 1ns/100ps
`include "formatBa_defines.svh"

module baFrameSequencer (
  input  logic                  macCoreTxClk,
  input  logic                  macCoreClkHardRst_n,
  // tx controller side
  input  logic                  sendBa,
  input  logic                  tickSifs,
  // FCS engine side
  input  logic                  fcsBusy,
  input  logic                  fcsEnd,
  // BA controller side
  input  logic                  psBitmapValid,
  // towards the byte selector
  output formatBaPkg::baStateT  state,
  output formatBaPkg::byteIdxT  byteIdx,
  // control strobes
  output logic                  baDone,
  output logic                  baTxStart,
  output logic                  baFcsEnable,
  output logic                  baFcsStart,
  output logic                  baFcsShift,
  output logic                  baFcsDataValid,
  output logic                  psBitmapReady
);

  import formatBaPkg::*;

  baStateT nextState;
  // index of the last byte of the current field
  byteIdxT lastIdx;
  // state presents a byte to the FCS engine
  logic    dataState;
  // a byte is taken by the FCS engine this cycle
  logic    byteAccept;
  // last byte of the field taken, move to next field
  logic    fieldDone;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      state <= baIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      // wait for a send request from the tx controller
      baIdle       : if (sendBa) nextState = baWait;
      // hold until the SIFS boundary
      baWait       : if (tickSifs) nextState = baStartTx;
      // single cycle, FCS engine start
      baStartTx    : nextState = baFrmCtrl1;
      baFrmCtrl1   : if (fieldDone) nextState = baFrmCtrl2;
      baFrmCtrl2   : if (fieldDone) nextState = baDurationId;
      baDurationId : if (fieldDone) nextState = baRa;
      baRa         : if (fieldDone) nextState = baTa;
      baTa         : if (fieldDone) nextState = baControl;
      baControl    : if (fieldDone) nextState = baInfo;
      baInfo       : if (fieldDone) nextState = baFcs;
      // checksum shifted out by the FCS engine
      baFcs        : if (fcsEnd) nextState = baIdle;
      default      : nextState = baIdle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-field byte counter
  ////////////////////////////////////////////////////////////////////////////

  // field length minus one, frame control bytes are single-byte fields
  always_comb
  begin
    case (state)
      baDurationId : lastIdx = byteIdxT'(`BA_DURATION_BYTES - 1);
      baRa         : lastIdx = byteIdxT'(`BA_ADDR_BYTES - 1);
      baTa         : lastIdx = byteIdxT'(`BA_ADDR_BYTES - 1);
      baControl    : lastIdx = byteIdxT'(`BA_CONTROL_BYTES - 1);
      baInfo       : lastIdx = byteIdxT'(`BA_INFO_BYTES - 1);
      default      : lastIdx = '0;
    endcase
  end

  assign dataState  = (state == baFrmCtrl1) || (state == baFrmCtrl2) ||
                      (state == baDurationId) || (state == baRa) ||
                      (state == baTa) || (state == baControl) ||
                      (state == baInfo);

  // bitmap bytes also need the BA controller to have one ready
  assign byteAccept = dataState && !fcsBusy && ((state != baInfo) || psBitmapValid);
  assign fieldDone  = byteAccept && (byteIdx == lastIdx);

  // counter wraps to zero on the last byte, ready for the next field
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      byteIdx <= '0;
    else if (fieldDone)
      byteIdx <= '0;
    else if (byteAccept)
      byteIdx <= byteIdx + byteIdxT'(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // control strobes
  ////////////////////////////////////////////////////////////////////////////

  // done one cycle after the FCS engine ends the checksum
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      baDone <= 1'b0;
    else
      baDone <= (state == baFcs) && fcsEnd;
  end

  // PHY start aligned on the SIFS tick
  assign baTxStart      = (state == baWait) && tickSifs;
  assign baFcsStart     = (state == baStartTx);
  assign baFcsEnable    = (state != baIdle);
  // from the last bitmap transfer until the checksum is out
  assign baFcsShift     = (nextState == baFcs) && !fcsEnd;
  assign baFcsDataValid = byteAccept;
  assign psBitmapReady  = (state == baInfo) && !fcsBusy;

endmodule

// ==== src/baFieldByteSelect.sv ====
// Block Ack frame byte selector
`timescale 1ns/100ps
`include "formatBa_defines.svh"

module baFieldByteSelect (
  // sequencer position
  input  formatBaPkg::baStateT  state,
  input  formatBaPkg::byteIdxT  byteIdx,
  // frame contents
  input  formatBaPkg::macAddrT  destAddr,
  input  formatBaPkg::macAddrT  srcAddr,
  input  formatBaPkg::durationT duration,
  input  formatBaPkg::tidT      rxTid,
  input  logic                  pwrMgt,
  input  formatBaPkg::fcsByteT  psBitmap,
  // byte to the FCS engine
  output formatBaPkg::fcsByteT  baFcsData
);

  import formatBaPkg::*;

  // picks one address byte, least significant first
  function automatic fcsByteT addrByte(input macAddrT addr, input byteIdxT idx);
    fcsByteT b;
    case (idx)
      4'd0    : b = addr[7:0];
      4'd1    : b = addr[15:8];
      4'd2    : b = addr[23:16];
      4'd3    : b = addr[31:24];
      4'd4    : b = addr[39:32];
      4'd5    : b = addr[47:40];
      default : b = '0;
    endcase
    return b;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // byte mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (state)
      baFrmCtrl1   : baFcsData = `BA_FRMCTRL_BYTE1;
      // order, wep, more data all zero, power mgt in bit 4
      baFrmCtrl2   : baFcsData = {3'b000, pwrMgt, 4'b0000};
      // duration low byte first
      baDurationId : baFcsData = byteIdx[0] ? duration[15:8] : duration[7:0];
      baRa         : baFcsData = addrByte(destAddr, byteIdx);
      baTa         : baFcsData = addrByte(srcAddr, byteIdx);
      // fixed control byte, then TID in the upper nibble
      baControl    : baFcsData = byteIdx[0] ? {rxTid, 4'b0000} : `BA_CONTROL_BYTE0;
      // bitmap passes straight through from the BA controller
      baInfo       : baFcsData = psBitmap;
      // no data in idle, wait, start and FCS states
      default      : baFcsData = '0;
    endcase
  end

endmodule

// ==== src/formatBa.sv ====
// Block Ack frame formatter
`timescale 1ns/100ps

module formatBa (
  input  logic                  macCoreTxClk,
  input  logic                  macCoreClkHardRst_n,
  // MAC controller fields, stable for the whole frame
  input  formatBaPkg::macAddrT  destAddr,
  input  formatBaPkg::macAddrT  srcAddr,
  input  formatBaPkg::durationT duration,
  input  formatBaPkg::tidT      rxTid,
  input  logic                  pwrMgt,
  // tx controller and timers
  input  logic                  sendBa,
  input  logic                  tickSifs,
  output logic                  baDone,
  output logic                  baTxStart,
  // FCS engine
  input  logic                  fcsBusy,
  input  logic                  fcsEnd,
  output logic                  baFcsEnable,
  output logic                  baFcsStart,
  output logic                  baFcsShift,
  output formatBaPkg::fcsByteT  baFcsData,
  output logic                  baFcsDataValid,
  // BA controller bitmap stream
  input  formatBaPkg::fcsByteT  psBitmap,
  input  logic                  psBitmapValid,
  output logic                  psBitmapReady
);

  import formatBaPkg::*;

  // sequencer position shared with the byte mux
  baStateT state;
  byteIdxT byteIdx;

  //////////////////////////////////////////////////////////////////////////
  // frame sequencing and strobes
  //////////////////////////////////////////////////////////////////////////

  baFrameSequencer uSequencer (
    .macCoreTxClk        (macCoreTxClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .sendBa              (sendBa),
    .tickSifs            (tickSifs),
    .fcsBusy             (fcsBusy),
    .fcsEnd              (fcsEnd),
    .psBitmapValid       (psBitmapValid),
    .state               (state),
    .byteIdx             (byteIdx),
    .baDone              (baDone),
    .baTxStart           (baTxStart),
    .baFcsEnable         (baFcsEnable),
    .baFcsStart          (baFcsStart),
    .baFcsShift          (baFcsShift),
    .baFcsDataValid      (baFcsDataValid),
    .psBitmapReady       (psBitmapReady)
  );

  // byte presented to the FCS engine
  baFieldByteSelect uByteSelect (
    .state     (state),
    .byteIdx   (byteIdx),
    .destAddr  (destAddr),
    .srcAddr   (srcAddr),
    .duration  (duration),
    .rxTid     (rxTid),
    .pwrMgt    (pwrMgt),
    .psBitmap  (psBitmap),
    .baFcsData (baFcsData)
  );

endmodule

// ==== verif/tbClockGen.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module tbClockGen #(
  parameter int period      = 10,
  parameter int resetCycles = 8
) (
  output logic macCoreTxClk,
  output logic macCoreClkHardRst_n
);

  initial
  begin
    macCoreTxClk = 1'b0;
    forever #(period / 2) macCoreTxClk = ~macCoreTxClk;
  end

  // reset low for a fixed number of cycles, released on a falling edge
  initial
  begin
    macCoreClkHardRst_n = 1'b0;
    repeat (resetCycles) @(posedge macCoreTxClk);
    @(negedge macCoreTxClk);
    macCoreClkHardRst_n = 1'b1;
  end

endmodule

// ==== verif/formatBa_sva.sv ====
// Block Ack formatter strobe assertions
`timescale 1ns/100ps

module formatBaSva (
  input logic macCoreTxClk,
  input logic macCoreClkHardRst_n,
  input logic baTxStart,
  input logic baFcsStart,
  input logic baDone,
  input logic fcsEnd,
  input logic fcsBusy,
  input logic baFcsDataValid
);

  // FCS start is one cycle wide, right after the PHY start
  startAfterTx: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    baTxStart |=> baFcsStart ##1 !baFcsStart)
    else $error("baFcsStart did not follow baTxStart for exactly one cycle");
  startHasTx: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    baFcsStart |-> $past(baTxStart))
    else $error("baFcsStart without a preceding baTxStart");

  // done one cycle after the checksum end
  doneAfterEnd: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    fcsEnd |=> baDone)
    else $error("baDone missing one cycle after fcsEnd");
  doneHasEnd: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    baDone |-> $past(fcsEnd))
    else $error("baDone without a preceding fcsEnd");

  // no byte while the FCS engine is busy
  noDataWhenBusy: assert property (@(posedge macCoreTxClk) disable iff (!macCoreClkHardRst_n)
    !(baFcsDataValid && fcsBusy))
    else $error("baFcsDataValid high while fcsBusy is high");

endmodule

// ==== verif/formatBaTb.sv ====
// Block Ack formatter testbench
`timescale 1ns/100ps

module formatBaTb;

  import formatBaPkg::*;

  localparam int clkPeriod   = 10;
  // longest run of busy or bitmap gap cycles from the models
  localparam int maxStall    = 3;
  localparam int frameCount  = 11;
  // 28 bytes with worst-case stalls, plus SIFS wait and checksum tail
  localparam int frameCycles = 28 * (2 * maxStall + 2) + 40;

  logic     macCoreTxClk;
  logic     macCoreClkHardRst_n;
  macAddrT  destAddr;
  macAddrT  srcAddr;
  durationT duration;
  tidT      rxTid;
  logic     pwrMgt;
  logic     sendBa;
  logic     tickSifs;
  logic     fcsBusy = 1'b0;
  logic     fcsEnd = 1'b0;
  fcsByteT  psBitmap = '0;
  logic     psBitmapValid = 1'b0;
  fcsByteT  baFcsData;
  logic     baDone, baTxStart, baFcsEnable, baFcsStart, baFcsShift;
  logic     baFcsDataValid, psBitmapReady;

  // model and scoreboard state
  fcsByteT  captured[$];
  fcsByteT  bitmapBytes[10];
  int       bitmapIdx, busyRun, gapRun, shiftCycles;
  int       cycle, txStartTotal, txStartCycle, fcsStartCount, fcsStartCycle;
  int       doneCount, doneCycle, fcsEndCycle;
  bit       busyMode, gapMode;
  bit       shiftWant, enableWant;
  string    curTest;

  tbClockGen #(.period(clkPeriod), .resetCycles(8)) uClockGen (
    .macCoreTxClk        (macCoreTxClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n)
  );

  formatBa DUT (.*);

  bind formatBa formatBaSva uSva (.*);

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
    assert (actual === expected)
    else reportFailure($sformatf("Mismatch in %s, %s: expected %0h, actual %0h",
                                 curTest, what, expected, actual));
  endtask

  //////////////////////////////////////////////////////////////////////////
  // FCS engine and BA controller models
  //////////////////////////////////////////////////////////////////////////

  always @(negedge macCoreTxClk)
  begin
    // busy runs capped so every byte gets through
    fcsBusy = busyMode && (busyRun < maxStall) && ($urandom % 3 == 0);
    busyRun = fcsBusy ? busyRun + 1 : 0;
    psBitmapValid = (bitmapIdx < 10) && (!gapMode || gapRun >= maxStall || $urandom % 2 == 0);
    gapRun = psBitmapValid ? 0 : gapRun + 1;
    psBitmap = (bitmapIdx < 10) ? bitmapBytes[bitmapIdx] : 8'h00;
    // checksum ends four cycles into the shift
    fcsEnd = !fcsEnd && (shiftCycles == 4);
  end

  always @(posedge macCoreTxClk)
  begin
    cycle++;
    if (macCoreClkHardRst_n)
    begin
      if (sendBa)
      begin
        captured.delete();
        bitmapIdx = 0;
        fcsStartCount = 0;
        doneCount = 0;
      end
      if (baFcsDataValid)
        captured.push_back(baFcsData);
      assert (!(baFcsDataValid && fcsBusy))
      else reportFailure($sformatf("%s: byte taken while fcsBusy was high", curTest));
      // a bitmap byte moves only with ready and valid both high
      assert (!psBitmapReady || (baFcsDataValid == psBitmapValid))
      else reportFailure($sformatf("%s: bitmap byte moved without a handshake", curTest));
      // shift from the last bitmap transfer until the checksum end
      shiftWant = (shiftWant || (psBitmapReady && psBitmapValid && bitmapIdx == 9)) && !fcsEnd;
      checkValue("baFcsShift", shiftWant, baFcsShift);
      // enable from the send request until the checksum end
      checkValue("baFcsEnable", enableWant, baFcsEnable);
      if (sendBa)
        enableWant = 1'b1;
      else if (fcsEnd)
        enableWant = 1'b0;
      if (psBitmapReady && psBitmapValid)
        bitmapIdx++;
      shiftCycles = baFcsShift ? shiftCycles + 1 : 0;
      assert (!baTxStart || tickSifs)
      else reportFailure($sformatf("%s: baTxStart high without a SIFS tick", curTest));
      if (baTxStart)
      begin
        txStartTotal++;
        txStartCycle = cycle;
      end
      if (baFcsStart)
      begin
        fcsStartCount++;
        fcsStartCycle = cycle;
      end
      if (fcsEnd)
        fcsEndCycle = cycle;
      if (baDone)
      begin
        doneCount++;
        doneCycle = cycle;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // one frame, checked against the field rules
  //////////////////////////////////////////////////////////////////////////

  task automatic runFrame(input bit busy, input bit gap, input logic pm, input tidT tid);
    fcsByteT expected[$];
    int      waited;
    int      txBefore;
    @(posedge macCoreTxClk);
    busyMode = busy;
    gapMode = gap;
    foreach (bitmapBytes[i])
      bitmapBytes[i] = fcsByteT'($urandom);
    txBefore = txStartTotal;
    @(negedge macCoreTxClk);
    destAddr = macAddrT'({$urandom, $urandom});
    srcAddr = macAddrT'({$urandom, $urandom});
    duration = durationT'($urandom);
    rxTid = tid;
    pwrMgt = pm;
    sendBa = 1'b1;
    @(negedge macCoreTxClk);
    sendBa = 1'b0;
    repeat (3) @(negedge macCoreTxClk);
    tickSifs = 1'b1;
    @(negedge macCoreTxClk);
    tickSifs = 1'b0;
    waited = 0;
    while (doneCount == 0 && waited < frameCycles)
    begin
      @(negedge macCoreTxClk);
      waited++;
    end
    if (doneCount == 0)
      reportFailure($sformatf("%s: frame did not finish, baDone never came", curTest));
    // frame control, duration and addresses low byte first, BA control, bitmap
    expected.push_back(8'h94);
    expected.push_back({3'b000, pm, 4'b0000});
    expected.push_back(duration[7:0]);
    expected.push_back(duration[15:8]);
    for (int i = 0; i < 6; i++)
      expected.push_back(destAddr[8*i +: 8]);
    for (int i = 0; i < 6; i++)
      expected.push_back(srcAddr[8*i +: 8]);
    expected.push_back(8'h04);
    expected.push_back({tid, 4'b0000});
    foreach (bitmapBytes[i])
      expected.push_back(bitmapBytes[i]);
    checkValue("byte count", 28, captured.size());
    foreach (expected[i])
      checkValue($sformatf("byte %0d", i), expected[i], captured[i]);
    checkValue("bitmap bytes consumed", 10, bitmapIdx);
    checkValue("baTxStart pulses", txBefore + 1, txStartTotal);
    checkValue("baFcsStart pulses", 1, fcsStartCount);
    checkValue("baFcsStart cycle", txStartCycle + 1, fcsStartCycle);
    checkValue("baDone pulses", 1, doneCount);
    checkValue("baDone cycle", fcsEndCycle + 1, doneCycle);
    checkValue("baFcsEnable after done", 0, baFcsEnable);
  endtask

  task automatic testResetState();
    curTest = "resetState";
    checkValue("control outputs", 0, {baDone, baTxStart, baFcsStart, baFcsShift,
                                      baFcsDataValid, baFcsEnable, psBitmapReady});
  endtask

  task automatic testStrobes();
    int txBefore;
    curTest = "strobes";
    // a SIFS tick while idle must not start the PHY
    txBefore = txStartTotal;
    @(negedge macCoreTxClk);
    tickSifs = 1'b1;
    @(negedge macCoreTxClk);
    tickSifs = 1'b0;
    checkValue("baTxStart while idle", txBefore, txStartTotal);
    runFrame(1'b0, 1'b0, 1'b1, 4'hf);
  endtask

  initial
  begin
    void'($urandom(32'hcd2));
    destAddr = '0;
    srcAddr = '0;
    duration = '0;
    rxTid = '0;
    pwrMgt = 1'b0;
    sendBa = 1'b0;
    tickSifs = 1'b0;
    @(posedge macCoreClkHardRst_n);
    @(negedge macCoreTxClk);
    testResetState();
    curTest = "cleanFrame";
    runFrame(1'b0, 1'b0, 1'b0, 4'h3);
    curTest = "fcsBackPressure";
    for (int i = 0; i < 3; i++)
      runFrame(1'b1, 1'b0, 1'(i), tidT'($urandom));
    curTest = "bitmapGaps";
    runFrame(1'b0, 1'b1, 1'b1, 4'h7);
    runFrame(1'b1, 1'b1, 1'b0, 4'h1);
    testStrobes();
    curTest = "fieldCodes";
    runFrame(1'b0, 1'b0, 1'b0, 4'h0);
    runFrame(1'b0, 1'b0, 1'b1, 4'h5);
    runFrame(1'b0, 1'b0, 1'b1, 4'ha);
    runFrame(1'b0, 1'b0, 1'b0, 4'hf);
    $display("All tests passed");
    $finish;
  end

  // watchdog sized from the frame bound and the frame count
  initial
  begin
    #(clkPeriod * (frameCount * (frameCycles + 10) + 50));
    reportFailure("watchdog timeout, the tests did not finish in time");
  end

endmodule

// ==== all.f ====
+incdir+src
src/formatBaPkg.sv
src/baFrameSequencer.sv
src/baFieldByteSelect.sv
src/formatBa.sv
verif/tbClockGen.sv
verif/formatBa_sva.sv
verif/formatBaTb.sv
